// ==== dv/tb_clkgen.sv ====
// ----------------------------------------------------------------------
// testbench clock and reset, 10 ns period
// reset is released on a falling edge after RESET_CYCLES rising edges
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int HALF_NS      = 5,  // half period
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rstn_o
);
    initial begin
        clk_o = 1'b0;
        forever #(HALF_NS) clk_o = ~clk_o;
    end

    initial begin
        rstn_o = 1'b0;                          // active low
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);                       // away from the rising edge
        rstn_o = 1'b1;
    end
endmodule

`default_nettype wire

// ==== dv/tb_fp16_normalizer.sv ====
// ----------------------------------------------------------------------
// testbench for the FP16 normalize-and-round unit with INT_W = 32
// inputs change on the falling edge and outputs are sampled there too
// below-point operands keep the sticky source bits clear
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_fp16_normalizer;
    import fpn_pkg::*;

    logic        clk_i;
    logic        rstn_i;
    logic        start_i;
    logic [2:0]  rmode_i;
    logic        funct_i;
    logic        sign_i;
    logic [5:0]  exponent_i;
    logic [21:0] mantissa_i;
    logic [31:0] integer_i;
    class_t      class_i;
    flags_t      flags_i;
    logic [15:0] result_o;
    flags_t      flags_o;
    logic        done_o;

    integer seed = 70714;
    int     checks = 0;
    int     errors = 0;
    int     test_checks = 0;
    int     test_errs = 0;
    logic   aborted = 1'b0;  // set on a timeout so later ops are skipped

    tb_clkgen u_clkgen (.clk_o(clk_i), .rstn_o(rstn_i));

    fp16_normalizer #(.INT_W(32)) dut (
        .clk_i(clk_i), .rstn_i(rstn_i), .start_i(start_i), .rmode_i(rmode_i),
        .funct_i(funct_i), .sign_i(sign_i), .exponent_i(exponent_i),
        .mantissa_i(mantissa_i), .integer_i(integer_i), .class_i(class_i),
        .flags_i(flags_i), .result_o(result_o), .flags_o(flags_o), .done_o(done_o)
    );

    task automatic note_error();
        errors++;
        test_errs++;
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] want);
        checks++;
        test_checks++;
        assert (got === want) else begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, want);
            note_error();
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %-10s %0d checks, %0d errors", name, test_checks, test_errs);
        test_checks = 0;
        test_errs   = 0;
    endtask

    // ------------------------------------------------------------------
    // expected value is mag / 2^frac_bits * 2^(eb - 15) rounded to FP16
    // ------------------------------------------------------------------
    task automatic expect_round(input logic s, input logic [2:0] rm, input logic [63:0] mag,
                                input int frac_bits, input int eb,
                                output logic [15:0] res, output flags_t flg);
        int          p;
        int          sh;
        int          e;
        logic [63:0] sig;
        logic        g;
        logic        rs;   // round or sticky
        logic        up;
        flg = '0;
        if (mag == 64'd0) begin
            res = 16'h0000;  // integer zero is +0
            return;
        end
        p = 63;
        while (p > 0 && mag[p] == 1'b0) p--;  // leading one
        e = eb + p - frac_bits;
        if (p > 10) begin
            sh  = p - 10;
            sig = mag >> sh;
            g   = mag[sh-1];
            rs  = (sh > 1) ? ((mag & ((64'd1 << (sh - 1)) - 64'd1)) != 64'd0) : 1'b0;
        end else begin
            sig = mag << (10 - p);
            g   = 1'b0;
            rs  = 1'b0;
        end
        case (rm)
            3'd0:    up = g & (rs | sig[0]);  // ties to even
            3'd2:    up = s & (g | rs);
            3'd3:    up = ~s & (g | rs);
            3'd4:    up = g;                  // ties away
            default: up = 1'b0;               // RTZ and unknown codes
        endcase
        sig = sig + 64'(up);
        if (sig[11]) begin
            sig = sig >> 1;  // renormalize after a carry out
            e++;
        end
        flg[FLG_NX] = up;
        if (e >= 31) begin
            res         = {s, 5'h1F, 10'h000};
            flg[FLG_OF] = 1'b1;
        end else if (e <= 0) begin
            res         = {s, 15'h0000};  // flushed
            flg[FLG_UF] = 1'b1;
        end else begin
            res = {s, 5'(e), sig[9:0]};
        end
    endtask

    // one operation is a start pulse and a wait for done with a timeout
    task automatic run_op(input logic fn, input logic s, input logic [2:0] rm,
                          input logic [5:0] ex, input logic [21:0] man, input logic [31:0] iv,
                          input class_t cls, input flags_t fl,
                          input logic [15:0] er, input flags_t ef);
        int n;
        if (aborted) return;
        funct_i = fn;
        sign_i = s;
        rmode_i = rm;
        exponent_i = ex;
        mantissa_i = man;
        integer_i = iv;
        class_i = cls;
        flags_i = fl;
        start_i = 1'b1;
        @(negedge clk_i);
        start_i = 1'b0;
        n = 0;
        while (!done_o && n < 100) begin
            @(negedge clk_i);
            n++;
        end
        if (!done_o) begin
            $display("timeout at %0t, done_o did not rise within 100 cycles", $time);
            note_error();
            aborted = 1'b1;
            return;
        end
        check_value("result_o", result_o, er);
        check_value("flags_o", 16'(flags_o), 16'(ef));
        @(negedge clk_i);
        check_value("done_o", 16'(done_o), 16'h0);  // one-cycle pulse
    endtask

    function automatic class_t class_bit(input int pos);
        return class_t'(1) << pos;
    endfunction

    task automatic int_op(input logic s, input logic [2:0] rm, input logic [31:0] iv);
        logic [15:0] er;
        flags_t      ef;
        expect_round(s, rm, 64'(iv), 0, 15, er, ef);
        run_op(1'b1, s, rm, 6'd0, 22'd0, iv,
               class_bit(s ? CLS_NEG_NORM : CLS_POS_NORM), '0, er, ef);
    endtask

    task automatic norm_op(input logic s, input logic [2:0] rm, input logic [5:0] ex,
                           input logic [21:0] man);
        logic [15:0] er;
        flags_t      ef;
        expect_round(s, rm, 64'({man[21:7], |man[6:0]}), 13, int'(ex), er, ef);
        run_op(1'b0, s, rm, ex, man, 32'd0,
               class_bit(s ? CLS_NEG_NORM : CLS_POS_NORM), '0, er, ef);
    endtask

    initial begin
        int          i;
        int          n;
        logic        s;
        logic [2:0]  rm;
        logic [5:0]  ex;
        logic [21:0] man;
        start_i = 1'b0;
        rmode_i = 3'd0;
        funct_i = 1'b0;
        sign_i = 1'b0;
        exponent_i = '0;
        mantissa_i = '0;
        integer_i = '0;
        class_i = '0;
        flags_i = '0;

        // ------------------------------------------------------------------
        // reset values and the done pulse
        // ------------------------------------------------------------------
        n = 0;
        while (rstn_i !== 1'b1 && n < 20) begin
            @(negedge clk_i);
            n++;
        end
        if (rstn_i !== 1'b1) begin
            $display("reset was never released");
            note_error();
            aborted = 1'b1;
        end
        @(negedge clk_i);
        check_value("done_o", 16'(done_o), 16'h0);
        check_value("result_o", result_o, 16'h0);
        check_value("flags_o", 16'(flags_o), 16'h0);
        int_op(1'b0, 3'd0, 32'd1);
        n = 0;
        for (i = 0; i < 20; i++) begin
            @(negedge clk_i);
            if (done_o) n++;  // no done without a start
        end
        check_value("done_o extra", 16'(n), 16'h0);
        finish_test("reset");

        for (rm = 3'd0; rm < 3'd5; rm++) begin
            for (i = 0; i <= 2048; i++) int_op(1'b0, rm, 32'(i));
            int_op(1'b1, rm, 32'd0);  // zero stays positive with the sign set
        end
        finish_test("small_int");

        for (i = 0; i < 2000; i++) begin
            s  = 1'($random(seed));
            rm = 3'($random(seed));
            int_op(s, rm, 32'($random(seed)) >> ($unsigned($random(seed)) % 32));
        end
        finish_test("rand_int");

        for (i = 0; i < 2000; i++) begin
            s   = 1'($random(seed));
            rm  = 3'($random(seed));
            man = 22'($random(seed));
            if ($random(seed) & 1) begin                // leading one above the point
                if (man[21:19] == 3'b0) man[19] = 1'b1;
                ex = 6'($unsigned($random(seed)) % 36);
            end else begin                              // leading one just below it
                man[21:19] = 3'b0;
                if (man[18:16] == 3'b0) man[16] = 1'b1;
                man[6:0] = 7'b0;
                ex = 6'(4 + $unsigned($random(seed)) % 30);
            end
            norm_op(s, rm, ex, man);
        end
        finish_test("rand_norm");

        // ------------------------------------------------------------------
        // special classes and incoming flags
        // ------------------------------------------------------------------
        man = 22'h2A5F3C;
        run_op(1'b0, 1'b0, 3'd0, 6'd20, man, 0, class_bit(CLS_QNAN), '0, 16'h7E00, 5'h00);
        run_op(1'b0, 1'b0, 3'd0, 6'd20, man, 0, class_bit(CLS_SNAN), '0, 16'h7E00, 5'h10);
        run_op(1'b0, 1'b0, 3'd1, 6'd20, man, 0, class_bit(CLS_POS_INF), '0, 16'h7C00, 5'h00);
        run_op(1'b0, 1'b1, 3'd2, 6'd20, man, 0, class_bit(CLS_NEG_INF), '0, 16'hFC00, 5'h00);
        run_op(1'b0, 1'b0, 3'd3, 6'd20, man, 0, class_bit(CLS_POS_ZERO), '0, 16'h0000, 5'h00);
        run_op(1'b0, 1'b1, 3'd4, 6'd20, man, 0, class_bit(CLS_NEG_ZERO), '0, 16'h8000, 5'h00);
        run_op(1'b0, 1'b0, 3'd0, 6'd20, man, 0, class_bit(CLS_POS_SUB), '0, 16'h0000, 5'h00);
        run_op(1'b0, 1'b1, 3'd0, 6'd20, man, 0, class_bit(CLS_NEG_SUB), '0, 16'h8000, 5'h00);
        run_op(1'b0, 1'b0, 3'd0, 6'd20, man, 0, class_bit(CLS_POS_NORM), 5'h10, 16'h7E00, 5'h10);
        run_op(1'b0, 1'b1, 3'd0, 6'd20, man, 0, class_bit(CLS_NEG_NORM), 5'h04, 16'hFC00, 5'h04);
        run_op(1'b0, 1'b1, 3'd0, 6'd20, man, 0, class_bit(CLS_NEG_NORM), 5'h02, 16'h8000, 5'h02);
        finish_test("special");

        $display("total %0d checks, %0d errors", checks, errors);
        if (errors == 0 && !aborted) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end
endmodule

`default_nettype wire

// ==== hdl/fp16_normalizer.sv ====
// ----------------------------------------------------------------------
// FP16 normalize-and-round unit, also converts integers to half
// one operation in flight, start while busy is dropped
// latency varies with the operand, done_o marks the end
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fp16_normalizer #(
    parameter int INT_W = 32  // 16 also supported
) (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          start_i,     // one-cycle pulse
    input  logic [2:0]                    rmode_i,
    input  logic                          funct_i,     // 1 = integer to half
    input  logic                          sign_i,
    input  logic [fpn_pkg::EXT_EXP_W-1:0] exponent_i,
    input  logic [fpn_pkg::EXT_MAN_W-1:0] mantissa_i,
    input  logic [INT_W-1:0]              integer_i,
    input  fpn_pkg::class_t               class_i,
    input  fpn_pkg::flags_t               flags_i,
    output logic [15:0]                   result_o,
    output fpn_pkg::flags_t               flags_o,
    output logic                          done_o
);
    import fpn_pkg::*;

    fpn_stage_if #(.INT_W(INT_W)) intake_if ();  // intake -> normalizer
    fpn_stage_if #(.INT_W(INT_W)) norm_if   ();  // normalizer -> rounder
    fpn_stage_if #(.INT_W(INT_W)) round_if  ();  // rounder -> packer

    fpn_intake #(.INT_W(INT_W)) u_intake (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .start_i    (start_i),
        .funct_i    (funct_i),
        .sign_i     (sign_i),
        .exponent_i (exponent_i),
        .mantissa_i (mantissa_i),
        .integer_i  (integer_i),
        .class_i    (class_i),
        .flags_i    (flags_i),
        .done_i     (done_o),  // releases busy
        .out_o      (intake_if.src)
    );

    fpn_normalizer #(.INT_W(INT_W)) u_normalizer (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .in_i   (intake_if.dst),
        .out_o  (norm_if.src)
    );

    fpn_rounder u_rounder (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .rmode_i (rmode_e'(rmode_i)),
        .in_i    (norm_if.dst),
        .out_o   (round_if.src)
    );

    fpn_packer u_packer (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .in_i     (round_if.dst),
        .result_o (result_o),
        .flags_o  (flags_o),
        .done_o   (done_o)
    );

endmodule

`default_nettype wire

// ==== hdl/fpn_intake.sv ====
// ----------------------------------------------------------------------
// stage 1, captures the operands and loads the shift register
// start is ignored while an operation is between accept and done
// the integer path assumes an unsigned magnitude with separate sign
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fpn_intake #(
    parameter int INT_W = 32
) (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          start_i,
    input  logic                          funct_i,     // 1 = integer to half
    input  logic                          sign_i,
    input  logic [fpn_pkg::EXT_EXP_W-1:0] exponent_i,
    input  logic [fpn_pkg::EXT_MAN_W-1:0] mantissa_i,
    input  logic [INT_W-1:0]              integer_i,
    input  fpn_pkg::class_t               class_i,
    input  fpn_pkg::flags_t               flags_i,
    input  logic                          done_i,      // from the packer
    fpn_stage_if.src                      out_o
);
    import fpn_pkg::*;

    logic busy_q;
    logic accept;
    logic int_zero;
    logic special;

    assign accept   = start_i & ~busy_q;
    assign int_zero = funct_i & (integer_i == '0);  // converting zero

    // classes and flags that skip the arithmetic
    assign special = class_i[CLS_SNAN]    | class_i[CLS_QNAN]     |
                     class_i[CLS_NEG_ZERO] | class_i[CLS_POS_ZERO] |
                     class_i[CLS_NEG_SUB]  | class_i[CLS_POS_SUB]  |
                     class_i[CLS_NEG_INF]  | class_i[CLS_POS_INF]  |
                     flags_i[FLG_UF] | flags_i[FLG_OF] | flags_i[FLG_NV];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q      <= 1'b0;
            out_o.valid <= 1'b0;
        end else begin
            out_o.valid <= accept;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (done_i) begin
                busy_q <= 1'b0;  // packer finished
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            out_o.sign    <= sign_i;
            out_o.flags   <= flags_i;
            out_o.bypass  <= special | int_zero;
            out_o.inexact <= 1'b0;
            out_o.cls     <= int_zero ? (class_i | class_t'(1 << CLS_POS_ZERO)) : class_i;
            if (funct_i) begin
                out_o.exp    <= NORM_EXP_W'(FP16_BIAS);  // value 1.0 when msb at bit 0
                out_o.sig_hi <= integer_i;
                out_o.sig_lo <= '0;
                out_o.grs    <= '0;
            end else begin
                out_o.exp    <= NORM_EXP_W'(exponent_i);          // zero extended
                out_o.sig_hi <= INT_W'(mantissa_i[21:19]);         // integer part
                out_o.sig_lo <= mantissa_i[18:9];                  // fraction
                out_o.grs    <= {mantissa_i[8], mantissa_i[7], |mantissa_i[6:0]};
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fpn_normalizer.sv ====
// ----------------------------------------------------------------------
// stage 2, one bit per cycle until the leading one sits at sig_hi[0]
// left shifts also stop once the exponent reaches 0 or below
// latency depends on the operand, bypassed items take one cycle
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fpn_normalizer #(
    parameter int INT_W = 32
) (
    input  logic     clk_i,
    input  logic     rstn_i,
    fpn_stage_if.dst in_i,
    fpn_stage_if.src out_o
);
    import fpn_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_DIR, ST_SHIFT} state_e;

    state_e                       state_q;
    logic                         valid_q;
    logic                         left_q;   // shift direction
    logic                         sign_q;
    logic signed [NORM_EXP_W-1:0] exp_q;
    logic [INT_W-1:0]             hi_q;
    logic [FP16_MAN_W-1:0]        lo_q;
    logic [2:0]                   grs_q;
    class_t                       cls_q;
    flags_t                       flags_q;
    logic                         bypass_q;
    logic                         inexact_q;
    logic                         stop;

    assign stop = (hi_q == INT_W'(1)) | (left_q & (exp_q <= 0));

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= ST_IDLE;
            valid_q <= 1'b0;
            left_q  <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (in_i.valid) begin
                        if (in_i.bypass) begin
                            valid_q <= 1'b1;  // straight through
                        end else begin
                            state_q <= ST_DIR;
                        end
                    end
                end
                ST_DIR: begin
                    left_q  <= (hi_q == '0);  // below 1.0
                    state_q <= ST_SHIFT;
                end
                ST_SHIFT: begin
                    if (stop) begin
                        valid_q <= 1'b1;
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // shift register
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if ((state_q == ST_IDLE) && in_i.valid) begin
            sign_q    <= in_i.sign;
            exp_q     <= in_i.exp;
            hi_q      <= in_i.sig_hi;
            lo_q      <= in_i.sig_lo;
            grs_q     <= in_i.grs;
            cls_q     <= in_i.cls;
            flags_q   <= in_i.flags;
            bypass_q  <= in_i.bypass;
            inexact_q <= in_i.inexact;
        end else if ((state_q == ST_SHIFT) && !stop) begin
            if (left_q) begin
                exp_q <= exp_q - 1'b1;
                hi_q  <= {hi_q[INT_W-2:0], lo_q[FP16_MAN_W-1]};
                lo_q  <= {lo_q[FP16_MAN_W-2:0], grs_q[2]};
                grs_q <= {grs_q[1], grs_q[0], grs_q[0]};  // sticky held
            end else begin
                exp_q <= exp_q + 1'b1;
                hi_q  <= {1'b0, hi_q[INT_W-1:1]};
                lo_q  <= {hi_q[0], lo_q[FP16_MAN_W-1:1]};
                grs_q <= {lo_q[0], grs_q[2], grs_q[1] | grs_q[0]};  // sticky collects
            end
        end
    end

    assign out_o.valid   = valid_q;
    assign out_o.sign    = sign_q;
    assign out_o.exp     = exp_q;
    assign out_o.sig_hi  = hi_q;
    assign out_o.sig_lo  = lo_q;
    assign out_o.grs     = grs_q;
    assign out_o.cls     = cls_q;
    assign out_o.flags   = flags_q;
    assign out_o.bypass  = bypass_q;
    assign out_o.inexact = inexact_q;

endmodule

`default_nettype wire

// ==== hdl/fpn_packer.sv ====
// ----------------------------------------------------------------------
// stage 4, range check, special values, flags and the result register
// subnormal results are flushed to a signed zero with UF
// result and flags hold until the next done pulse
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fpn_packer (
    input  logic            clk_i,
    input  logic            rstn_i,
    fpn_stage_if.dst        in_i,
    output logic [15:0]     result_o,
    output fpn_pkg::flags_t flags_o,
    output logic            done_o
);
    import fpn_pkg::*;

    logic        of;
    logic        uf;
    flags_t      flags_n;
    logic [15:0] result_n;

    // range only matters when the item went through the arithmetic
    assign of = ~in_i.bypass & (in_i.exp >= FP16_EXP_MAX);
    assign uf = ~in_i.bypass & ((in_i.exp <= 0) | ~in_i.sig_hi[0]);  // or no hidden one

    always_comb begin
        flags_n         = in_i.flags;
        flags_n[FLG_NV] = in_i.flags[FLG_NV] | in_i.cls[CLS_SNAN];
        flags_n[FLG_OF] = in_i.flags[FLG_OF] | of;
        flags_n[FLG_UF] = in_i.flags[FLG_UF] | uf;
        flags_n[FLG_NX] = in_i.flags[FLG_NX] | in_i.inexact;
    end

    // ------------------------------------------------------------------
    // result select, order matters
    // ------------------------------------------------------------------
    always_comb begin
        if (in_i.cls[CLS_SNAN] | in_i.cls[CLS_QNAN] | in_i.flags[FLG_NV]) begin
            result_n = FP16_QNAN;
        end else if (in_i.cls[CLS_NEG_INF] | in_i.cls[CLS_POS_INF] | flags_n[FLG_OF]) begin
            result_n = {in_i.sign, {FP16_EXP_W{1'b1}}, {FP16_MAN_W{1'b0}}};
        end else if (in_i.cls[CLS_NEG_ZERO] | in_i.cls[CLS_POS_ZERO]) begin
            result_n = {in_i.cls[CLS_NEG_ZERO], 15'd0};  // sign from class
        end else if (flags_n[FLG_UF] | in_i.cls[CLS_NEG_SUB] | in_i.cls[CLS_POS_SUB]) begin
            result_n = {in_i.sign, 15'd0};  // flush to zero
        end else begin
            result_n = {in_i.sign, in_i.exp[FP16_EXP_W-1:0], in_i.sig_lo};
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            result_o <= '0;
            flags_o  <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= in_i.valid;
            if (in_i.valid) begin
                result_o <= result_n;
                flags_o  <= flags_n;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fpn_pkg.sv ====
// ----------------------------------------------------------------------
// shared widths, class and flag bit positions for the FP16 normalizer
// extended mantissa is 3 integer bits, 10 fraction bits, G, R, 7 sticky
// rounding modes follow the RISC-V encoding, unknown codes truncate
// ----------------------------------------------------------------------
`default_nettype none

package fpn_pkg;

    localparam int FP16_EXP_W   = 5;   // packed exponent
    localparam int FP16_MAN_W   = 10;  // stored fraction
    localparam int EXT_EXP_W    = 6;   // incoming extended exponent
    localparam int EXT_MAN_W    = 22;  // incoming extended mantissa
    localparam int NORM_EXP_W   = 8;   // internal signed exponent, no wrap
    localparam int FP16_BIAS    = 15;
    localparam int FP16_EXP_MAX = 31;  // all-ones exponent

    localparam logic [15:0] FP16_QNAN = 16'h7E00;  // canonical quiet NaN

    // ------------------------------------------------------------------
    // class vector, one-hot by convention
    // ------------------------------------------------------------------
    typedef logic [9:0] class_t;

    localparam int CLS_NEG_INF  = 0;
    localparam int CLS_NEG_NORM = 1;
    localparam int CLS_NEG_SUB  = 2;
    localparam int CLS_NEG_ZERO = 3;
    localparam int CLS_POS_ZERO = 4;
    localparam int CLS_POS_SUB  = 5;
    localparam int CLS_POS_NORM = 6;
    localparam int CLS_POS_INF  = 7;
    localparam int CLS_SNAN     = 8;
    localparam int CLS_QNAN     = 9;

    // ------------------------------------------------------------------
    // exception flags, RISC-V fflags order
    // ------------------------------------------------------------------
    typedef logic [4:0] flags_t;

    localparam int FLG_NX = 0;  // inexact
    localparam int FLG_UF = 1;  // underflow
    localparam int FLG_OF = 2;  // overflow
    localparam int FLG_DZ = 3;  // divide by zero, passed through only
    localparam int FLG_NV = 4;  // invalid

    typedef enum logic [2:0] {
        RM_RNE = 3'd0,  // nearest, ties to even
        RM_RTZ = 3'd1,  // toward zero
        RM_RDN = 3'd2,  // toward -inf
        RM_RUP = 3'd3,  // toward +inf
        RM_RMM = 3'd4   // nearest, ties to max magnitude
    } rmode_e;

endpackage

`default_nettype wire

// ==== hdl/fpn_rounder.sv ====
// ----------------------------------------------------------------------
// stage 3, rounds the 11-bit significand in a single cycle
// a carry out needs only one right shift, done here
// rmode_i is sampled when the item arrives, hold it stable meanwhile
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fpn_rounder (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  fpn_pkg::rmode_e rmode_i,
    fpn_stage_if.dst        in_i,
    fpn_stage_if.src        out_o
);
    import fpn_pkg::*;

    logic [FP16_MAN_W:0]   sig;   // hidden bit + fraction
    logic [FP16_MAN_W+1:0] sum;   // one extra for the carry
    logic                  up;
    logic                  carry;

    assign sig = {in_i.sig_hi[0], in_i.sig_lo};

    always_comb begin
        case (rmode_i)
            RM_RNE:  up = in_i.grs[2] & (in_i.grs[1] | in_i.grs[0] | sig[0]);
            RM_RTZ:  up = 1'b0;
            RM_RDN:  up = in_i.sign & (|in_i.grs);
            RM_RUP:  up = ~in_i.sign & (|in_i.grs);
            RM_RMM:  up = in_i.grs[2];
            default: up = 1'b0;  // unknown mode truncates
        endcase
        if (in_i.bypass) begin
            up = 1'b0;
        end
    end

    assign sum   = {1'b0, sig} + (FP16_MAN_W + 2)'(up);
    assign carry = sum[FP16_MAN_W+1];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            out_o.valid <= 1'b0;
        end else begin
            out_o.valid <= in_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_i.valid) begin
            out_o.sign    <= in_i.sign;
            out_o.cls     <= in_i.cls;
            out_o.flags   <= in_i.flags;
            out_o.bypass  <= in_i.bypass;
            out_o.inexact <= in_i.inexact | up;
            if (in_i.bypass) begin
                out_o.exp    <= in_i.exp;
                out_o.sig_hi <= in_i.sig_hi;
                out_o.sig_lo <= in_i.sig_lo;
                out_o.grs    <= in_i.grs;
            end else begin
                out_o.exp       <= in_i.exp + NORM_EXP_W'(carry);  // renormalize
                out_o.sig_hi    <= '0;
                out_o.sig_hi[0] <= carry | sum[FP16_MAN_W];
                out_o.sig_lo    <= carry ? sum[FP16_MAN_W:1] : sum[FP16_MAN_W-1:0];
                out_o.grs       <= '0;  // consumed by rounding
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fpn_stage_if.sv ====
// ----------------------------------------------------------------------
// one operation passed between two adjacent stages
// payload is only meaningful in the cycle valid is high, no ready
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface fpn_stage_if #(
    parameter int INT_W = 32
);
    import fpn_pkg::*;

    logic                         valid;    // one-cycle strobe
    logic                         sign;
    logic signed [NORM_EXP_W-1:0] exp;      // biased, may go out of range
    logic [INT_W-1:0]             sig_hi;   // bits above the binary point
    logic [FP16_MAN_W-1:0]        sig_lo;   // fraction
    logic [2:0]                   grs;      // guard, round, sticky
    class_t                       cls;
    flags_t                       flags;
    logic                         bypass;   // special case, no arithmetic
    logic                         inexact;  // rounded up somewhere

    modport src (output valid, sign, exp, sig_hi, sig_lo, grs, cls, flags, bypass, inexact);
    modport dst (input  valid, sign, exp, sig_hi, sig_lo, grs, cls, flags, bypass, inexact);

endinterface

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the FP16 normalizer testbench with Verilator and runs it.
# Exits non-zero when the build, the run or the log check fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_fp16_normalizer

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -f verilog.f -o sim_"$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Everything OK" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== verilog.f ====
hdl/fpn_pkg.sv
hdl/fpn_stage_if.sv
hdl/fpn_intake.sv
hdl/fpn_normalizer.sv
hdl/fpn_rounder.sv
hdl/fpn_packer.sv
hdl/fp16_normalizer.sv
dv/tb_clkgen.sv
dv/tb_fp16_normalizer.sv
